//--- src.f
src/img_pkg.sv
src/fmap_ram.sv
src/fmap_arbiter.sv
src/view_window.sv
src/op_sequencer.sv
src/image_loader.sv
src/window_reader.sv
src/img_core.sv
verif/clk_gen.sv
verif/tb_img_core.sv

//--- Makefile
# Verilator build and run for the feature-map control core

VERILATOR  ?= verilator
TOP        ?= tb_img_core
FILELIST   ?= src.f
BUILD_DIR  ?= obj_dir
TIMESCALE  ?= 1ns/1ps
VFLAGS     ?= --binary --timing --assert --timescale $(TIMESCALE)
LINT_FLAGS ?= --lint-only --timing --timescale $(TIMESCALE)

SOURCES := $(wildcard src/*.sv verif/*.sv)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run lint clean

all: run

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

//--- verif/tb_img_core.sv
`default_nettype none

module tb_img_core
	import img_pkg::*;
();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int unsigned MAX_BYTE_CYCLES = 4;   // strobe plus a gap of up to three
	localparam int unsigned OP_CYCLES       = 16;  // ready to ready for a short op
	localparam int unsigned NUM_OPS         = 40;
	localparam int unsigned DISP_WORDS      = 544; // 3x128 + 32 + 2x64
	localparam int unsigned RUN_CYCLES      = FMAP_DEPTH * MAX_BYTE_CYCLES + DISP_WORDS
		+ NUM_OPS * OP_CYCLES;
	localparam int unsigned WATCHDOG_CYCLES = 2 * RUN_CYCLES + 100;

	logic        clk, rst_n;
	logic        op_valid, op_ready;
	op_mode_t    op_mode;
	logic        in_valid, in_ready;
	pixel_t      in_data;
	logic        out_valid;
	out_word_t   out_data;
	pixel_t      model_img [NUM_CHAN][IMG_DIM][IMG_DIM]; // expected image, [chan][y][x]
	int unsigned model_x, model_y;       // expected view origin
	int unsigned model_chans;            // 8, 16 or 32
	logic [15:0] lfsr_q;
	int unsigned words_seen;             // all valid words so far
	int unsigned disp_base, disp_len;
	logic        disp_active;

	clk_gen u_clk_gen (
		.o_clk   (clk),
		.o_rst_n (rst_n)
	);

	img_core i_img_core (
		.i_clk       (clk),
		.i_rst_n     (rst_n),
		.i_op_valid  (op_valid),
		.i_op_mode   (op_mode),
		.o_op_ready  (op_ready),
		.i_in_valid  (in_valid),
		.i_in_data   (in_data),
		.o_in_ready  (in_ready),
		.o_out_valid (out_valid),
		.o_out_data  (out_data)
	);

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("*** TEST FAILED ***");
		$fatal(1, "stopping at first error");
	endtask

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	function automatic int unsigned rand_bits(input int unsigned n);
		int unsigned v;
		v = 0;
		for (int unsigned k = 0; k < n; k++) begin
			lfsr_q = lfsr_next(lfsr_q); // one step per bit
			v      = (v << 1) | int'(lfsr_q[0]);
		end
		return v;
	endfunction

	// scan order is channel, then y, then x
	function automatic out_word_t ref_word(input int unsigned idx);
		int unsigned ch, py, px;
		ch = idx / 4;
		py = model_y + (idx / 2) % 2;
		px = model_x + idx % 2;
		return out_word_t'(model_img[ch][py][px]); // zero in the upper bits
	endfunction

	function automatic void update_model_view(input logic [3:0] code);
		case (code)
			OP_RIGHT: begin
				if (model_x < ORIGIN_MAX)
					model_x = model_x + 1;
			end
			OP_LEFT: begin
				if (model_x > 0)
					model_x = model_x - 1;
			end
			OP_DOWN: begin
				if (model_y < ORIGIN_MAX)
					model_y = model_y + 1;
			end
			OP_UP: begin
				if (model_y > 0)
					model_y = model_y - 1;
			end
			OP_WIN_DOWN: begin
				if (model_chans > 8)
					model_chans = model_chans / 2;
			end
			OP_WIN_UP: begin
				if (model_chans < NUM_CHAN)
					model_chans = model_chans * 2;
			end
			default: ; // load, display and codes 8..15 leave the view alone
		endcase
	endfunction

	task automatic check_low(input string name, input logic value);
		assert (value === 1'b0) else
			fail_run($sformatf("ERR %s: got 0x%h expected 0x0", name, value));
	endtask

	task automatic wait_ready();
		@(posedge clk);
		while (!op_ready)
			@(posedge clk);
	endtask

	// called on the edge that saw the ready pulse
	task automatic send_op(input logic [3:0] code);
		op_valid <= 1'b1;
		op_mode  <= op_mode_t'(code);
		@(posedge clk);
		op_valid <= 1'b0;
	endtask

	task automatic run_short_op(input logic [3:0] code);
		int unsigned base;
		base = words_seen;
		send_op(code);
		update_model_view(code);
		wait_ready();
		assert (words_seen == base) else
			fail_run($sformatf("op code %0d produced output words", code));
	endtask

	task automatic run_display();
		disp_base   = words_seen;
		disp_len    = 4 * model_chans;
		disp_active = 1'b1;
		send_op(OP_DISPLAY);
		wait_ready(); // next pulse comes after the last word
		disp_active = 1'b0;
		assert (words_seen - disp_base == disp_len) else
			fail_run($sformatf("ERR o_out_valid count: got 0x%h expected 0x%h",
				words_seen - disp_base, disp_len));
	endtask

	task automatic run_load();
		pixel_t      px;
		int unsigned gap;
		int unsigned ch, y, x;
		logic        started;
		started = 1'b0;
		send_op(OP_LOAD);
		for (int unsigned i = 0; i < FMAP_DEPTH; i++) begin
			px  = pixel_t'(rand_bits(8));
			gap = rand_bits(2);
			x   = i % IMG_DIM; // x fastest, then y, then channel
			y   = (i / IMG_DIM) % IMG_DIM;
			ch  = i / (IMG_DIM * IMG_DIM);
			model_img[ch][y][x] = px;
			repeat (gap) begin
				@(posedge clk);
				in_valid <= 1'b0;
			end
			@(posedge clk);
			while (!in_ready) begin
				assert (!started) else
					fail_run("o_in_ready fell before all 2048 bytes were taken");
				in_valid <= 1'b0;
				@(posedge clk);
			end
			in_valid <= 1'b1;
			in_data  <= px;
			started = 1'b1;
		end
		@(posedge clk);
		in_valid <= 1'b0;
		wait_ready();
		check_low("o_in_ready", in_ready);
	endtask

	// compare every output word against the model
	always @(posedge clk) begin
		int unsigned idx;
		out_word_t   exp_word;
		if (rst_n === 1'b1 && out_valid === 1'b1) begin
			assert (disp_active) else
				fail_run("o_out_valid went high while no display was running");
			idx = words_seen - disp_base;
			assert (idx < disp_len) else
				fail_run($sformatf("display gave more than %0d words", disp_len));
			exp_word = ref_word(idx);
			assert (out_data === exp_word) else
				fail_run($sformatf("ERR o_out_data word %0d: got 0x%h expected 0x%h",
					idx, out_data, exp_word));
			words_seen = words_seen + 1;
		end
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		fail_run($sformatf("timeout, run not finished after %0d clock cycles",
			WATCHDOG_CYCLES));
	end

	initial begin
		op_valid    = 1'b0;
		op_mode     = OP_LOAD;
		in_valid    = 1'b0;
		in_data     = '0;
		lfsr_q      = 16'd86;
		model_x     = 0;
		model_y     = 0;
		model_chans = NUM_CHAN; // window resets to full depth
		words_seen  = 0;
		disp_base   = 0;
		disp_len    = 0;
		disp_active = 1'b0;

		while (rst_n !== 1'b1)
			@(posedge clk);
		@(posedge clk);
		check_low("o_op_ready", op_ready);
		check_low("o_in_ready", in_ready);
		check_low("o_out_valid", out_valid);
		wait_ready(); // first pulse after reset

		run_load();
		run_display(); // origin (0,0), 32 channels

		repeat (8) run_short_op(OP_RIGHT); // saturates at 6
		repeat (8) run_short_op(OP_DOWN);
		run_display();
		repeat (3) run_short_op(OP_LEFT);
		repeat (2) run_short_op(OP_UP);
		run_display();

		repeat (3) run_short_op(OP_WIN_DOWN); // third one clamps at 8
		run_display();
		run_short_op(OP_WIN_UP);
		run_display();

		for (int unsigned c = 8; c < 16; c++)
			run_short_op(4'(c));
		run_display(); // view must be unchanged

		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

`default_nettype wire

//--- verif/clk_gen.sv
`default_nettype none

module clk_gen (
	output logic o_clk,
	output logic o_rst_n
);
	timeunit 1ns;
	timeprecision 1ps;

	localparam int unsigned HALF_PERIOD = 5; // 10 ns clock
	localparam int unsigned RST_CYCLES  = 8;

	initial begin
		o_clk = 1'b0;
		forever #HALF_PERIOD o_clk = ~o_clk;
	end

	initial begin
		o_rst_n = 1'b0;
		repeat (RST_CYCLES) @(posedge o_clk);
		o_rst_n <= 1'b1; // release on a rising edge
	end

endmodule

`default_nettype wire

//--- src/img_core.sv
`default_nettype none

module img_core import img_pkg::*; (
	input  logic      i_clk,
	input  logic      i_rst_n,
	input  logic      i_op_valid,
	input  op_mode_t  i_op_mode,
	output logic      o_op_ready,
	input  logic      i_in_valid,
	input  pixel_t    i_in_data,
	output logic      o_in_ready,
	output logic      o_out_valid,
	output out_word_t o_out_data
);
	logic       load_start, load_done;   // sequencer <-> loader
	logic       disp_start, disp_done;   // sequencer <-> reader
	logic       view_strobe;
	op_mode_t   view_op;
	coord_t     origin_x, origin_y;
	chan_win_t  chan_win;
	logic       ld_req, ld_gnt;          // loader side of the arbiter
	fmap_addr_t ld_addr;
	pixel_t     ld_data;
	logic       rd_req, rd_gnt;          // reader side of the arbiter
	fmap_addr_t rd_addr;
	fmap_addr_t mem_addr;                // single memory port
	logic       mem_we;
	pixel_t     mem_wdata, mem_rdata;

	op_sequencer u_op_sequencer (
		.i_clk         (i_clk),
		.i_rst_n       (i_rst_n),
		.i_op_valid    (i_op_valid),
		.i_op_mode     (i_op_mode),
		.i_load_done   (load_done),
		.i_disp_done   (disp_done),
		.o_op_ready    (o_op_ready),
		.o_load_start  (load_start),
		.o_disp_start  (disp_start),
		.o_view_strobe (view_strobe),
		.o_view_op     (view_op)
	);

	view_window u_view_window (
		.i_clk         (i_clk),
		.i_rst_n       (i_rst_n),
		.i_view_strobe (view_strobe),
		.i_view_op     (view_op),
		.o_origin_x    (origin_x),
		.o_origin_y    (origin_y),
		.o_chan_win    (chan_win)
	);

	image_loader u_image_loader (
		.i_clk      (i_clk),
		.i_rst_n    (i_rst_n),
		.i_start    (load_start),
		.i_in_valid (i_in_valid),
		.i_in_data  (i_in_data),
		.i_gnt      (ld_gnt),
		.o_in_ready (o_in_ready),
		.o_req      (ld_req),
		.o_wr_addr  (ld_addr),
		.o_wr_data  (ld_data),
		.o_done     (load_done)
	);

	window_reader u_window_reader (
		.i_clk       (i_clk),
		.i_rst_n     (i_rst_n),
		.i_start     (disp_start),
		.i_origin_x  (origin_x),
		.i_origin_y  (origin_y),
		.i_chan_win  (chan_win),
		.i_gnt       (rd_gnt),
		.i_rd_data   (mem_rdata),
		.o_req       (rd_req),
		.o_rd_addr   (rd_addr),
		.o_out_valid (o_out_valid),
		.o_out_data  (o_out_data),
		.o_done      (disp_done)
	);

	fmap_arbiter u_fmap_arbiter (
		.i_ld_req    (ld_req),
		.i_ld_addr   (ld_addr),
		.i_ld_data   (ld_data),
		.i_rd_req    (rd_req),
		.i_rd_addr   (rd_addr),
		.o_ld_gnt    (ld_gnt),
		.o_rd_gnt    (rd_gnt),
		.o_mem_addr  (mem_addr),
		.o_mem_we    (mem_we),
		.o_mem_wdata (mem_wdata)
	);

	fmap_ram u_fmap_ram (
		.i_clk   (i_clk),
		.i_we    (mem_we),
		.i_addr  (mem_addr),
		.i_wdata (mem_wdata),
		.o_rdata (mem_rdata)
	);

endmodule

`default_nettype wire

//--- src/window_reader.sv
`default_nettype none

module window_reader import img_pkg::*; (
	input  logic       i_clk,
	input  logic       i_rst_n,
	input  logic       i_start,
	input  coord_t     i_origin_x,
	input  coord_t     i_origin_y,
	input  chan_win_t  i_chan_win,
	input  logic       i_gnt,
	input  pixel_t     i_rd_data,
	output logic       o_req,
	output fmap_addr_t o_rd_addr,
	output logic       o_out_valid,
	output out_word_t  o_out_data,
	output logic       o_done
);
	logic   busy;
	coord_t org_x, org_y;       // origin frozen for the whole scan
	chan_t  last_ch;
	coord_t cur_x, cur_y;
	chan_t  cur_ch;
	logic   issue;              // address accepted by the memory
	logic   x_end, y_end, scan_end;
	logic   rd_valid, rd_last;  // stage 1, data on the memory output
	logic   out_last;           // stage 2, beside o_out_valid

	assign o_req    = busy;
	assign issue    = busy & i_gnt;
	assign x_end    = (cur_x != org_x);   // second column of the view
	assign y_end    = (cur_y != org_y);
	assign scan_end = x_end & y_end & (cur_ch == last_ch);
	assign o_rd_addr = fmap_addr_t'(cur_ch * IMG_DIM * IMG_DIM + cur_y * IMG_DIM + cur_x);
	assign o_done   = out_last;         // high with the final word

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			busy    <= 1'b0;
			org_x   <= '0;
			org_y   <= '0;
			last_ch <= '0;
			cur_x   <= '0;
			cur_y   <= '0;
			cur_ch  <= '0;
		end else if (i_start) begin
			busy    <= 1'b1;
			org_x   <= i_origin_x;
			org_y   <= i_origin_y;
			cur_x   <= i_origin_x;
			cur_y   <= i_origin_y;
			cur_ch  <= '0;
			case (i_chan_win)
				WIN_8:   last_ch <= 5'd7;
				WIN_16:  last_ch <= 5'd15;
				default: last_ch <= chan_t'(NUM_CHAN - 1);
			endcase
		end else if (issue) begin
			cur_x <= x_end ? org_x : cur_x + 3'd1; // x fastest
			if (x_end) begin
				cur_y <= y_end ? org_y : cur_y + 3'd1;
				if (y_end)
					cur_ch <= cur_ch + 5'd1; // channel outermost
			end
			if (scan_end)
				busy <= 1'b0;
		end
	end

	// two-stage valid pipe matches ram read plus output register
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			rd_valid    <= 1'b0;
			rd_last     <= 1'b0;
			o_out_valid <= 1'b0;
			out_last    <= 1'b0;
		end else begin
			rd_valid    <= issue;
			rd_last     <= issue & scan_end;
			o_out_valid <= rd_valid;
			out_last    <= rd_last;
		end
	end

	always_ff @(posedge i_clk) begin
		if (rd_valid)
			o_out_data <= {6'b0, i_rd_data}; // zero extend pixel
	end

endmodule

`default_nettype wire

//--- src/image_loader.sv
`default_nettype none

module image_loader import img_pkg::*; (
	input  logic       i_clk,
	input  logic       i_rst_n,
	input  logic       i_start,
	input  logic       i_in_valid,
	input  pixel_t     i_in_data,
	input  logic       i_gnt,
	output logic       o_in_ready,
	output logic       o_req,
	output fmap_addr_t o_wr_addr,
	output pixel_t     o_wr_data,
	output logic       o_done
);
	logic       in_valid_q; // registered byte strobe
	pixel_t     in_data_q;
	logic       wr_fire;    // byte goes to memory this cycle
	logic       wr_last;

	assign o_req     = o_in_ready & in_valid_q; // bytes outside a load are dropped
	assign wr_fire   = o_req & i_gnt;
	assign wr_last   = wr_fire & (o_wr_addr == fmap_addr_t'(FMAP_DEPTH - 1));
	assign o_wr_data = in_data_q;

	always_ff @(posedge i_clk)
		in_data_q <= i_in_data;

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			in_valid_q <= 1'b0;
			o_in_ready <= 1'b0;
			o_wr_addr  <= '0;
			o_done     <= 1'b0;
		end else begin
			in_valid_q <= i_in_valid;
			o_done     <= wr_last;
			if (i_start) begin
				o_in_ready <= 1'b1;
				o_wr_addr  <= '0;
			end else if (wr_fire) begin
				o_wr_addr <= o_wr_addr + 11'd1; // raster order is address order
				if (wr_last)
					o_in_ready <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

//--- src/op_sequencer.sv
`default_nettype none

module op_sequencer import img_pkg::*; (
	input  logic     i_clk,
	input  logic     i_rst_n,
	input  logic     i_op_valid,
	input  op_mode_t i_op_mode,
	input  logic     i_load_done,
	input  logic     i_disp_done,
	output logic     o_op_ready,
	output logic     o_load_start,
	output logic     o_disp_start,
	output logic     o_view_strobe,
	output op_mode_t o_view_op
);
	logic       op_valid_q;   // op strobe, one cycle late
	op_mode_t   op_mode_q;    // op code, held until the next strobe
	seq_state_t state, state_nx;
	logic [1:0] boot_cnt;     // settle time before the first ready pulse

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			op_valid_q <= 1'b0;
			op_mode_q  <= OP_LOAD;
			state      <= S_START;
			boot_cnt   <= '0;
		end else begin
			op_valid_q <= i_op_valid;
			if (i_op_valid)
				op_mode_q <= i_op_mode; // latch only on strobe so view ops see a stable code
			state <= state_nx;
			if (state == S_START)
				boot_cnt <= boot_cnt + 2'd1;
		end
	end

	assign o_view_op = op_mode_q;

	always_comb begin
		state_nx      = state;
		o_op_ready    = 1'b0;
		o_load_start  = 1'b0;
		o_disp_start  = 1'b0;
		o_view_strobe = 1'b0;
		case (state)
			S_START: begin
				if (&boot_cnt)
					state_nx = S_READY;
			end
			S_READY: begin
				o_op_ready = 1'b1; // single pulse, testbench answers next cycle
				state_nx   = S_WAIT_OP;
			end
			S_WAIT_OP: begin
				if (op_valid_q) begin
					case (op_mode_q)
						OP_LOAD: begin
							o_load_start = 1'b1; // loader raises in_ready next cycle
							state_nx     = S_LOAD;
						end
						OP_DISPLAY: begin
							o_disp_start = 1'b1;
							state_nx     = S_DISPLAY;
						end
						OP_RIGHT, OP_LEFT, OP_UP, OP_DOWN, OP_WIN_DOWN, OP_WIN_UP: begin
							state_nx = S_VIEW;
						end
						default: state_nx = S_FINISH; // 8..15 accepted and dropped
					endcase
				end
			end
			S_LOAD: begin
				if (i_load_done)
					state_nx = S_FINISH;
			end
			S_VIEW: begin
				o_view_strobe = 1'b1; // exactly one update per op
				state_nx      = S_FINISH;
			end
			S_DISPLAY: begin
				if (i_disp_done)
					state_nx = S_FINISH;
			end
			S_FINISH: state_nx = S_READY;
			default:  state_nx = S_START;
		endcase
	end

endmodule

`default_nettype wire

//--- src/view_window.sv
`default_nettype none

module view_window import img_pkg::*; (
	input  logic      i_clk,
	input  logic      i_rst_n,
	input  logic      i_view_strobe,
	input  op_mode_t  i_view_op,
	output coord_t    o_origin_x,
	output coord_t    o_origin_y,
	output chan_win_t o_chan_win
);
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_origin_x <= '0;
			o_origin_y <= '0;
			o_chan_win <= WIN_32; // full depth after reset
		end else if (i_view_strobe) begin
			case (i_view_op)
				OP_RIGHT: begin
					if (o_origin_x < coord_t'(ORIGIN_MAX))
						o_origin_x <= o_origin_x + 3'd1;
				end
				OP_LEFT: begin
					if (o_origin_x != '0)
						o_origin_x <= o_origin_x - 3'd1;
				end
				OP_DOWN: begin
					if (o_origin_y < coord_t'(ORIGIN_MAX))
						o_origin_y <= o_origin_y + 3'd1; // y grows downwards
				end
				OP_UP: begin
					if (o_origin_y != '0)
						o_origin_y <= o_origin_y - 3'd1;
				end
				OP_WIN_DOWN: begin
					if (o_chan_win != WIN_8)
						o_chan_win <= chan_win_t'(o_chan_win - 2'd1); // 32 -> 16 -> 8
				end
				OP_WIN_UP: begin
					if (o_chan_win != WIN_32)
						o_chan_win <= chan_win_t'(o_chan_win + 2'd1);
				end
				default: ; // load and display never strobe here
			endcase
		end
	end

endmodule

`default_nettype wire

//--- src/fmap_arbiter.sv
`default_nettype none

module fmap_arbiter import img_pkg::*; (
	input  logic       i_ld_req,
	input  fmap_addr_t i_ld_addr,
	input  pixel_t     i_ld_data,
	input  logic       i_rd_req,
	input  fmap_addr_t i_rd_addr,
	output logic       o_ld_gnt,
	output logic       o_rd_gnt,
	output fmap_addr_t o_mem_addr,
	output logic       o_mem_we,
	output pixel_t     o_mem_wdata
);
	// loader wins any collision, reader stalls its counters
	assign o_ld_gnt = i_ld_req;
	assign o_rd_gnt = i_rd_req & ~i_ld_req;

	assign o_mem_addr  = o_ld_gnt ? i_ld_addr : i_rd_addr;
	assign o_mem_we    = o_ld_gnt; // every loader grant is a write
	assign o_mem_wdata = i_ld_data;

endmodule

`default_nettype wire

//--- src/fmap_ram.sv
`default_nettype none

module fmap_ram import img_pkg::*; (
	input  logic       i_clk,
	input  logic       i_we,
	input  fmap_addr_t i_addr,
	input  pixel_t     i_wdata,
	output pixel_t     o_rdata
);
	pixel_t mem [FMAP_DEPTH]; // one word per (chan, y, x)

	always_ff @(posedge i_clk) begin
		if (i_we)
			mem[i_addr] <= i_wdata;
		o_rdata <= mem[i_addr]; // data one cycle after the address
	end

endmodule

`default_nettype wire

//--- src/img_pkg.sv
`default_nettype none

package img_pkg;

	localparam int unsigned IMG_DIM    = 8;    // image width and height in pixels
	localparam int unsigned NUM_CHAN   = 32;   // channels stored per pixel
	localparam int unsigned ORIGIN_MAX = 6;    // last origin that keeps the 2x2 view inside
	localparam int unsigned FMAP_DEPTH = 2048; // IMG_DIM * IMG_DIM * NUM_CHAN words

	typedef logic [2:0]  coord_t;     // pixel coordinate 0..7
	typedef logic [4:0]  chan_t;      // channel index 0..31
	typedef logic [7:0]  pixel_t;     // stored pixel
	typedef logic [13:0] out_word_t;  // output stream word
	typedef logic [10:0] fmap_addr_t; // chan*64 + y*8 + x

	typedef enum logic [3:0] {
		OP_LOAD     = 4'd0,
		OP_RIGHT    = 4'd1,
		OP_LEFT     = 4'd2,
		OP_UP       = 4'd3,
		OP_DOWN     = 4'd4,
		OP_WIN_DOWN = 4'd5,
		OP_WIN_UP   = 4'd6,
		OP_DISPLAY  = 4'd7
	} op_mode_t; // codes 8..15 carry no name and are ignored

	typedef enum logic [1:0] {
		WIN_8  = 2'd0,
		WIN_16 = 2'd1,
		WIN_32 = 2'd2
	} chan_win_t;

	typedef enum logic [2:0] {
		S_START,
		S_READY,
		S_WAIT_OP,
		S_LOAD,
		S_VIEW,
		S_DISPLAY,
		S_FINISH
	} seq_state_t;

endpackage

`default_nettype wire
